// ==== Bender.yml ====
package:
  name: mcu_dbus

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mcu_pkg.sv
      - rtl/dbus_interconnect.sv
      - rtl/data_mem.sv
      - rtl/clint_timer.sv
      - rtl/gpio_port.sv
      - rtl/mcu_dbus_top.sv
  - target: simulation
    files:
      - verification/mcu_dbus_tb.sv

// ==== mcu_dbus_top.f ====
+incdir+rtl
rtl/mcu_pkg.sv
rtl/dbus_interconnect.sv
rtl/data_mem.sv
rtl/clint_timer.sv
rtl/gpio_port.sv
rtl/mcu_dbus_top.sv
verification/mcu_dbus_tb.sv

// ==== rtl/clint_timer.sv ====
// Machine timer with a single 32-bit mtime and mtimecmp
// Registers take full-word writes only, byte enables are ignored

`timescale 1ns/10ps
`include "mcu_config.svh"

module clint_timer (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                sel_i,
    input  mcu_pkg::dbus_addr_u addr_i,
    input  logic                we_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o,
    output logic                timer_irq_o
);
    import mcu_pkg::*;

    logic [31:0] mtime_q;
    logic [31:0] mtimecmp_q;
    logic        wr_mtime;
    logic        wr_mtimecmp;

    assign wr_mtime    = sel_i && we_i && (addr_i.periph.reg_idx == 2'd0);
    assign wr_mtimecmp = sel_i && we_i && (addr_i.periph.reg_idx == 2'd1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= `MCU_MTIMECMP_RST;
        end else begin
            if (wr_mtime) begin
                mtime_q <= wdata_i;     // Write wins over the increment
            end else begin
                mtime_q <= mtime_q + 32'd1;
            end
            if (wr_mtimecmp) mtimecmp_q <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (sel_i) begin
            case (addr_i.periph.reg_idx)
                2'd0:    rdata_o <= mtime_q;
                2'd1:    rdata_o <= mtimecmp_q;
                default: rdata_o <= '0;
            endcase
        end
    end

    // Level interrupt, cleared by moving mtimecmp above mtime
    always_ff @(posedge clk) begin
        if (rst_i) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule : clint_timer

// ==== rtl/data_mem.sv ====
// Word-addressed data memory, depth set by MCU_DMEM_AW
// A write returns the old word, and the contents are not cleared by reset

`timescale 1ns/10ps
`include "mcu_config.svh"

module data_mem (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                sel_i,
    input  mcu_pkg::dbus_addr_u addr_i,
    input  logic                we_i,
    input  logic [3:0]          be_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o
);
    import mcu_pkg::*;

    logic [31:0] mem [2**`MCU_DMEM_AW];

    always_ff @(posedge clk) begin
        if (sel_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) mem[addr_i.mem.word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (sel_i) begin
            rdata_o <= mem[addr_i.mem.word_idx];    // Pre-write contents on a write
        end
    end

endmodule : data_mem

// ==== rtl/dbus_interconnect.sv ====
// Four-phase req/ack slave with one transfer in flight
// Peripherals must return registered data one cycle after their select pulse

`timescale 1ns/10ps

module dbus_interconnect (
    input  logic                clk,
    input  logic                rst_i,

    input  logic                dbus_req_i,
    input  logic [31:0]         dbus_addr_i,
    input  logic                dbus_we_i,
    input  logic [3:0]          dbus_be_i,
    input  logic [31:0]         dbus_wdata_i,
    output logic                dbus_ack_o,
    output logic [31:0]         dbus_rdata_o,
    output logic                dbus_err_o,

    output mcu_pkg::dbus_addr_u peri_addr_o,
    output logic                peri_we_o,
    output logic [3:0]          peri_be_o,
    output logic [31:0]         peri_wdata_o,
    output logic                dmem_sel_o,
    output logic                clint_sel_o,
    output logic                gpio_sel_o,

    input  logic [31:0]         dmem_rdata_i,
    input  logic [31:0]         clint_rdata_i,
    input  logic [31:0]         gpio_rdata_i
);
    import mcu_pkg::*;

    typedef enum logic [1:0] {st_idle, st_access, st_respond} state_e;

    state_e     state_q;
    region_e    region_q;       // Region of the transfer in flight
    region_e    region_d;
    dbus_addr_u req_addr;

    assign req_addr = dbus_addr_i;

    always_comb begin
        case (req_addr.periph.region)
            region_dmem:  region_d = region_dmem;
            region_clint: region_d = region_clint;
            region_gpio:  region_d = region_gpio;
            default:      region_d = region_none;
        endcase
    end

    // Request fields held for the peripherals
    always_ff @(posedge clk) begin
        if (state_q == st_idle && dbus_req_i) begin
            peri_addr_o  <= req_addr;
            peri_we_o    <= dbus_we_i;
            peri_be_o    <= dbus_be_i;
            peri_wdata_o <= dbus_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= st_idle;
            region_q    <= region_none;
            dmem_sel_o  <= 1'b0;
            clint_sel_o <= 1'b0;
            gpio_sel_o  <= 1'b0;
            dbus_ack_o  <= 1'b0;
            dbus_err_o  <= 1'b0;
        end else begin
            dmem_sel_o  <= 1'b0;    // Select lines are single-cycle pulses
            clint_sel_o <= 1'b0;
            gpio_sel_o  <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (dbus_req_i) begin
                        region_q    <= region_d;
                        dmem_sel_o  <= (region_d == region_dmem);
                        clint_sel_o <= (region_d == region_clint);
                        gpio_sel_o  <= (region_d == region_gpio);
                        state_q     <= st_access;
                    end
                end
                st_access: state_q <= st_respond;   // Peripheral registers its word
                st_respond: begin
                    if (!dbus_ack_o) begin
                        dbus_ack_o <= 1'b1;
                        dbus_err_o <= (region_q == region_none);
                    end else if (!dbus_req_i) begin
                        dbus_ack_o <= 1'b0;
                        dbus_err_o <= 1'b0;
                        state_q    <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Read data captured together with the rising ack
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dbus_rdata_o <= '0;
        end else if (state_q == st_respond && !dbus_ack_o) begin
            case (region_q)
                region_dmem:  dbus_rdata_o <= dmem_rdata_i;
                region_clint: dbus_rdata_o <= clint_rdata_i;
                region_gpio:  dbus_rdata_o <= gpio_rdata_i;
                default:      dbus_rdata_o <= '0;   // Unmapped reads as zero
            endcase
        end
    end

endmodule : dbus_interconnect

// ==== rtl/gpio_port.sv ====
// LED outputs and 16 asynchronous switch inputs with a change interrupt
// A switch edge shows in the status three cycles after the pins move

`timescale 1ns/10ps
`include "mcu_config.svh"

module gpio_port (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                sel_i,
    input  mcu_pkg::dbus_addr_u addr_i,
    input  logic                we_i,
    input  logic [31:0]         wdata_i,
    output logic [31:0]         rdata_o,
    input  logic [15:0]         gp_switch_i,
    output logic [15:0]         gp_led_o,
    output logic                gpio_irq_o
);
    import mcu_pkg::*;

    logic [15:0] sw_meta;
    logic [15:0] sw_sync;
    logic [15:0] sw_prev;       // Detector flop
    logic [15:0] status_q;
    logic [15:0] clr_bits;

    assign clr_bits = (sel_i && we_i && addr_i.periph.reg_idx == 2'd2) ? wdata_i[15:0] : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            gp_led_o <= `MCU_LED_RST;
            sw_meta  <= '0;
            sw_sync  <= '0;
            sw_prev  <= '0;
            status_q <= '0;
        end else begin
            if (sel_i && we_i && addr_i.periph.reg_idx == 2'd0) gp_led_o <= wdata_i[15:0];
            sw_meta  <= gp_switch_i;
            sw_sync  <= sw_meta;
            sw_prev  <= sw_sync;
            status_q <= (status_q & ~clr_bits) | (sw_sync ^ sw_prev);   // New change beats clear
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (sel_i) begin
            case (addr_i.periph.reg_idx)
                2'd0:    rdata_o <= {16'h0, gp_led_o};
                2'd1:    rdata_o <= {16'h0, sw_sync};
                2'd2:    rdata_o <= {16'h0, status_q};
                default: rdata_o <= '0;
            endcase
        end
    end

    assign gpio_irq_o = |status_q;

endmodule : gpio_port

// ==== rtl/mcu_config.svh ====
// Address map, memory depth and reset values for the data-bus subsystem
// Region codes sit in address bits 31:28, and MCU_DMEM_AW sets the memory size

`ifndef MCU_CONFIG_SVH
`define MCU_CONFIG_SVH

// Data memory word-address width, 256 words
`define MCU_DMEM_AW        8

// Region codes in address bits 31:28
`define MCU_REGION_DMEM    4'h0
`define MCU_REGION_CLINT   4'h2
`define MCU_REGION_GPIO    4'h4

// Timer compare starts at all ones so the interrupt stays quiet
`define MCU_MTIMECMP_RST   32'hFFFF_FFFF
`define MCU_LED_RST        16'h0000

`endif

// ==== rtl/mcu_dbus_top.sv ====
// Data-bus subsystem top, the master port stands in for a load/store unit
// Master must follow the four-phase handshake with one transfer at a time

`timescale 1ns/10ps

module mcu_dbus_top (
    input  logic        clk,
    input  logic        rst_i,

    // Master port
    input  logic        dbus_req_i,
    input  logic [31:0] dbus_addr_i,
    input  logic        dbus_we_i,
    input  logic [3:0]  dbus_be_i,
    input  logic [31:0] dbus_wdata_i,
    output logic        dbus_ack_o,
    output logic [31:0] dbus_rdata_o,
    output logic        dbus_err_o,

    input  logic [15:0] gp_switch_i,
    output logic [15:0] gp_led_o,
    output logic        timer_irq_o,
    output logic        gpio_irq_o
);
    import mcu_pkg::*;

    dbus_addr_u  peri_addr;     // Shared by all peripherals
    logic        peri_we;
    logic [3:0]  peri_be;
    logic [31:0] peri_wdata;
    logic        dmem_sel;
    logic        clint_sel;
    logic        gpio_sel;
    logic [31:0] dmem_rdata;
    logic [31:0] clint_rdata;
    logic [31:0] gpio_rdata;

    dbus_interconnect dbus_interconnect_module (
        .clk           (clk),
        .rst_i         (rst_i),
        .dbus_req_i    (dbus_req_i),
        .dbus_addr_i   (dbus_addr_i),
        .dbus_we_i     (dbus_we_i),
        .dbus_be_i     (dbus_be_i),
        .dbus_wdata_i  (dbus_wdata_i),
        .dbus_ack_o    (dbus_ack_o),
        .dbus_rdata_o  (dbus_rdata_o),
        .dbus_err_o    (dbus_err_o),
        .peri_addr_o   (peri_addr),
        .peri_we_o     (peri_we),
        .peri_be_o     (peri_be),
        .peri_wdata_o  (peri_wdata),
        .dmem_sel_o    (dmem_sel),
        .clint_sel_o   (clint_sel),
        .gpio_sel_o    (gpio_sel),
        .dmem_rdata_i  (dmem_rdata),
        .clint_rdata_i (clint_rdata),
        .gpio_rdata_i  (gpio_rdata)
    );

    data_mem data_mem_module (
        .clk     (clk),
        .rst_i   (rst_i),
        .sel_i   (dmem_sel),
        .addr_i  (peri_addr),
        .we_i    (peri_we),
        .be_i    (peri_be),
        .wdata_i (peri_wdata),
        .rdata_o (dmem_rdata)
    );

    clint_timer clint_timer_module (
        .clk         (clk),
        .rst_i       (rst_i),
        .sel_i       (clint_sel),
        .addr_i      (peri_addr),
        .we_i        (peri_we),
        .wdata_i     (peri_wdata),
        .rdata_o     (clint_rdata),
        .timer_irq_o (timer_irq_o)
    );

    gpio_port gpio_port_module (
        .clk         (clk),
        .rst_i       (rst_i),
        .sel_i       (gpio_sel),
        .addr_i      (peri_addr),
        .we_i        (peri_we),
        .wdata_i     (peri_wdata),
        .rdata_o     (gpio_rdata),
        .gp_switch_i (gp_switch_i),
        .gp_led_o    (gp_led_o),
        .gpio_irq_o  (gpio_irq_o)
    );

endmodule : mcu_dbus_top

// ==== rtl/mcu_pkg.sv ====
// Shared bus types. The address word carries two views, one for the data
// memory and one for the register-mapped peripherals

`include "mcu_config.svh"

package mcu_pkg;

    // Anything outside the three known codes is unmapped
    typedef enum logic [3:0] {
        region_dmem  = `MCU_REGION_DMEM,
        region_clint = `MCU_REGION_CLINT,
        region_gpio  = `MCU_REGION_GPIO,
        region_none  = 4'hF
    } region_e;

    // Memory view of the address
    typedef struct packed {
        region_e                      region;
        logic [27-`MCU_DMEM_AW-2:0]   pad;
        logic [`MCU_DMEM_AW-1:0]      word_idx;
        logic [1:0]                   byte_off;
    } dbus_mem_addr_s;

    // Peripheral register view of the address
    typedef struct packed {
        region_e                      region;
        logic [23:0]                  pad;
        logic [1:0]                   reg_idx;
        logic [1:0]                   byte_off;
    } dbus_periph_addr_s;

    typedef union packed {
        dbus_mem_addr_s               mem;
        dbus_periph_addr_s            periph;
    } dbus_addr_u;

endpackage : mcu_pkg

// ==== verification/mcu_dbus_stim.txt ====
# W addr data be exp_err | R addr exp_data exp_err | S switches
# I exp_timer_irq exp_gpio_irq | Q random_word_count, all values hex except Q
I 0 0
W 00000000 11111111 F 0
W 00000004 DEADBEEF F 0
W 00000010 0BADF00D F 0
W 00000200 80000001 F 0
W 000003FC CAFEBABE F 0
R 00000000 11111111 0
R 00000010 0BADF00D 0
R 00000200 80000001 0
R 000003FC CAFEBABE 0
W 00000004 11223344 5 0
R 00000004 DE22BE44 0
W 00000004 AABBCCDD A 0
R 00000004 AA22CC44 0
W 20000000 00000000 F 0
W 20000004 FFFF0000 F 0
I 0 0
W 20000004 00000000 F 0
I 1 0
R 20000004 00000000 0
W 40000000 0000A5C3 F 0
R 40000000 0000A5C3 0
S 00F0
I 1 1
R 40000008 000000F0 0
W 40000008 000000F0 F 0
I 1 0
S 0F30
R 40000008 00000FC0 0
W 40000008 00000FC0 F 0
I 1 0
W F0000010 12345678 F 1
R F0000010 00000000 1
R 00000010 0BADF00D 0
Q 24

// ==== verification/mcu_dbus_tb.sv ====
// Plays verification/mcu_dbus_stim.txt through the master port when run from the project root
// Random memory traffic is checked against a model array kept here

`timescale 1ns/10ps

module mcu_dbus_tb;

    localparam int ACK_WAIT = 20;           // Cycles allowed for each handshake edge

    logic        clk = 1'b0;
    logic        rst;
    logic        dbus_req;
    logic [31:0] dbus_addr;
    logic        dbus_we;
    logic [3:0]  dbus_be;
    logic [31:0] dbus_wdata;
    logic        dbus_ack;
    logic [31:0] dbus_rdata;
    logic        dbus_err;
    logic [15:0] gp_switch;
    logic [15:0] gp_led;
    logic        timer_irq;
    logic        gpio_irq;

    int          mismatches = 0;
    int          hangs = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 200;         // Raised as stimulus lines are read
    int          seed = 52893;
    logic [31:0] model [256];
    logic        written [256];

    always #2 clk = ~clk;

    mcu_dbus_top mcu_dbus_top_inst (
        .clk          (clk),
        .rst_i        (rst),
        .dbus_req_i   (dbus_req),
        .dbus_addr_i  (dbus_addr),
        .dbus_we_i    (dbus_we),
        .dbus_be_i    (dbus_be),
        .dbus_wdata_i (dbus_wdata),
        .dbus_ack_o   (dbus_ack),
        .dbus_rdata_o (dbus_rdata),
        .dbus_err_o   (dbus_err),
        .gp_switch_i  (gp_switch),
        .gp_led_o     (gp_led),
        .timer_irq_o  (timer_irq),
        .gpio_irq_o   (gpio_irq)
    );

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing the stimulus", cycles);
            $display("Errors: %0d mismatches, %0d hung handshakes, %0d other",
                     mismatches, hangs, other_errors);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_fields(input int got, input int need, input logic [7:0] op);
        if (got != need) begin
            $display("Stimulus line for op '%c' has %0d fields where %0d are needed",
                     op, got, need);
            other_errors++;
        end
    endtask

    // One full four-phase transfer with responses sampled on the falling edge
    task automatic bus_transfer(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        dbus_req   <= 1'b1;
        dbus_addr  <= addr;
        dbus_we    <= we;
        dbus_be    <= be;
        dbus_wdata <= wdata;
        @(negedge clk);
        while (!dbus_ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!dbus_ack) begin
            $display("Handshake hung at %0t, ack never rose for address %h", $time, addr);
            hangs++;
        end
        rdata = dbus_rdata;
        err   = dbus_err;
        @(posedge clk);
        dbus_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (dbus_ack && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (dbus_ack) begin
            $display("Handshake hung at %0t, ack stayed high for address %h", $time, addr);
            hangs++;
        end
    endtask

    initial begin : stimulus
        int               fd;
        int               code;
        int               count;
        int               idx;
        logic [7:0]       op;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [3:0]       be;
        logic             exp_err;
        logic             exp_timer;
        logic             exp_gpio;
        logic [31:0]      rdata;
        logic             err;
        logic             matched;
        logic [8*128-1:0] comment;

        rst        = 1'b1;
        dbus_req   = 1'b0;
        dbus_addr  = '0;
        dbus_we    = 1'b0;
        dbus_be    = '0;
        dbus_wdata = '0;
        gp_switch  = '0;
        for (int i = 0; i < 256; i++) written[i] = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("verification/mcu_dbus_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/mcu_dbus_stim.txt");
            other_errors++;
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                cycle_limit += 12;
                case (op)
                    "#": code = $fgets(comment, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h %h %h", addr, data, be, exp_err);
                        check_fields(code, 4, op);
                        bus_transfer(addr, 1'b1, be, data, rdata, err);
                        check_value($sformatf("err of write to %h", addr), err, exp_err);
                        if (exp_err) begin     // Failed access returns no data
                            check_value($sformatf("rdata of write to %h", addr), rdata, 32'h0);
                        end
                        if (addr == 32'h4000_0000) check_value("gp_led_o", gp_led, data[15:0]);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h", addr, data, exp_err);
                        check_fields(code, 3, op);
                        bus_transfer(addr, 1'b0, 4'h0, 32'h0, rdata, err);
                        check_value($sformatf("read data at %h", addr), rdata, data);
                        check_value($sformatf("err of read at %h", addr), err, exp_err);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h", data);
                        check_fields(code, 1, op);
                        @(posedge clk);
                        gp_switch <= data[15:0];
                        matched = 1'b0;
                        for (int n = 0; n < 10 && !matched; n++) begin   // Synchronizer delay
                            bus_transfer(32'h4000_0004, 1'b0, 4'h0, 32'h0, rdata, err);
                            matched = (rdata === {16'h0, data[15:0]}) && (err === 1'b0);
                        end
                        if (!matched) begin
                            $display("[FAIL] %0t: switch register never read %h", $time,
                                     data[15:0]);
                            mismatches++;
                        end
                    end
                    "I": begin
                        code = $fscanf(fd, "%h %h", exp_timer, exp_gpio);
                        check_fields(code, 2, op);
                        @(negedge clk);
                        check_value("timer_irq_o", timer_irq, exp_timer);
                        check_value("gpio_irq_o", gpio_irq, exp_gpio);
                    end
                    "Q": begin
                        code = $fscanf(fd, "%d", count);
                        check_fields(code, 1, op);
                        cycle_limit += 40 * count;
                        for (int n = 0; n < count; n++) begin
                            idx          = $random(seed) & 255;
                            data         = $random(seed);
                            model[idx]   = data;
                            written[idx] = 1'b1;
                            bus_transfer({22'h0, idx[7:0], 2'b00}, 1'b1, 4'hF, data, rdata, err);
                        end
                        for (int i = 0; i < 256; i++) begin
                            if (written[i]) begin
                                bus_transfer({22'h0, i[7:0], 2'b00}, 1'b0, 4'h0, 32'h0,
                                             rdata, err);
                                check_value($sformatf("random word %0d", i), rdata, model[i]);
                            end
                        end
                    end
                    default: begin
                        $display("Unknown stimulus op '%c' in the stimulus file", op);
                        other_errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d hung handshakes, %0d other",
                 mismatches, hangs, other_errors);
        if (mismatches + hangs + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : mcu_dbus_tb
